//--- cnnPipe_macros.svh
`ifndef CNN_PIPE_MACROS_SVH
`define CNN_PIPE_MACROS_SVH

// Activation sample and weight width
`define CNN_SAMPLE_W 16

// Product, sum and ALU result width
`define CNN_WIDE_W 32

// Activation lanes per item
`define CNN_DATA_LANES 5

// Adder terms, five products plus bias
`define CNN_TERM_LANES 6

`endif

//--- cnnDataPkg.sv
`default_nettype none

`include "cnnPipe_macros.svh"

package cnnDataPkg;

    // One signed activation sample or weight
    typedef logic signed [`CNN_SAMPLE_W-1:0] sample_t;

    // Product, sum or ALU result
    typedef logic signed [`CNN_WIDE_W-1:0] wide_t;

    // Five activation lanes, lane0 in the low bits
    typedef struct packed {
        sample_t lane4;
        sample_t lane3;
        sample_t lane2;
        sample_t lane1;
        sample_t lane0;
    } dataLanes_t;

    // Lane weights plus bias weight on top
    typedef struct packed {
        sample_t bias;
        sample_t lane4;
        sample_t lane3;
        sample_t lane2;
        sample_t lane1;
        sample_t lane0;
    } weightLanes_t;

    // Adder terms, term5 is the bias term
    typedef struct packed {
        wide_t term5;
        wide_t term4;
        wide_t term3;
        wide_t term2;
        wide_t term1;
        wide_t term0;
    } termLanes_t;

endpackage

`default_nettype wire

//--- cnnCtrlPkg.sv
`default_nettype none

`include "cnnPipe_macros.svh"

package cnnCtrlPkg;

    ////////////////////////////////
    // Per-item control word
    ////////////////////////////////

    typedef struct packed {
        // One enable per adder term, bit 5 is bias
        logic [`CNN_TERM_LANES-1:0] laneEnable;
        // Raw samples into the adder
        logic bypass;
        // Feed back previous ALU result
        logic accumulate;
        // Pooling path as ALU result
        logic selectMax;
        // Global pooling latch update
        logic runningMax;
        // Latch back to most negative sample
        logic clearMax;
        // Item closes an output
        logic done;
    } ctrlWord_t;

    // Bubble word, no lanes, latch cleared
    localparam ctrlWord_t ctrlIdle = '{
        laneEnable: '0,
        bypass:     1'b0,
        accumulate: 1'b0,
        selectMax:  1'b0,
        runningMax: 1'b0,
        clearMax:   1'b1,
        done:       1'b0
    };

endpackage

`default_nettype wire

//--- operandStage.sv
`timescale 1ns/10ps
`default_nettype none

module operandStage
    import cnnDataPkg::*;
    import cnnCtrlPkg::*;
(
    input  wire          Clk,
    input  wire          rstN,
    input  wire          enable,
    input  ctrlWord_t    ctrlIn,
    input  dataLanes_t   dataIn,
    input  weightLanes_t weightIn,
    output ctrlWord_t    ctrlOut,
    output dataLanes_t   dataOut,
    output weightLanes_t weightOut
);

    ////////////////////////////////
    // Stage one register
    ////////////////////////////////

    // Sampled at edge k
    // Both compute paths read from here
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            ctrlOut   <= '0;
            dataOut   <= '0;
            weightOut <= '0;
        end else if (enable) begin
            // Live item
            ctrlOut   <= ctrlIn;
            dataOut   <= dataIn;
            weightOut <= weightIn;
        end else begin
            // Idle bubble
            // No done, no lanes, latch gets cleared downstream
            ctrlOut   <= ctrlIdle;
            dataOut   <= '0;
            weightOut <= '0;
        end
    end

endmodule

`default_nettype wire

//--- macLanes.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnPipe_macros.svh"

module macLanes
    import cnnDataPkg::*;
    import cnnCtrlPkg::*;
(
    input  wire          Clk,
    input  wire          rstN,
    input  ctrlWord_t    ctrl,
    input  dataLanes_t   data,
    input  weightLanes_t weight,
    input  wide_t        accRes,
    output wide_t        sumRes
);

    // Lane views of the operand structs
    sample_t [`CNN_DATA_LANES-1:0] dataArr;
    sample_t [`CNN_TERM_LANES-1:0] weightArr;

    // Terms before and after the stage two register
    wide_t [`CNN_TERM_LANES-1:0] termNext;
    termLanes_t                  termReg;
    wide_t [`CNN_TERM_LANES-1:0] termArr;
    logic                        accReg;

    // Adder tree nodes
    wide_t pairA;
    wide_t pairB;
    wide_t pairC;
    wide_t feedBack;

    assign dataArr   = data;
    assign weightArr = weight;

    ////////////////////////////////
    // Multiply, bypass and mask
    ////////////////////////////////

    always_comb begin
        for (int i = 0; i < `CNN_DATA_LANES; i++) begin
            if (ctrl.bypass)
                // Sign-extended raw sample
                termNext[i] = wide_t'(dataArr[i]);
            else if (ctrl.laneEnable[i])
                termNext[i] = wide_t'(dataArr[i]) * wide_t'(weightArr[i]);
            else
                termNext[i] = '0;
        end
        // Bias term, dropped under bypass
        if (!ctrl.bypass && ctrl.laneEnable[`CNN_TERM_LANES-1])
            termNext[`CNN_TERM_LANES-1] = wide_t'(weightArr[`CNN_TERM_LANES-1]);
        else
            termNext[`CNN_TERM_LANES-1] = '0;
    end

    // Stage two, terms travel with their accumulate bit
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            termReg <= '0;
            accReg  <= 1'b0;
        end else begin
            termReg <= termNext;
            accReg  <= ctrl.accumulate;
        end
    end

    ////////////////////////////////
    // Adder tree
    ////////////////////////////////

    assign termArr = termReg;

    // accRes is the previous item's ALU result, so chains run back-to-back
    assign feedBack = accReg ? accRes : '0;
    assign pairA    = termArr[0] + termArr[1];
    assign pairB    = termArr[2] + termArr[3];
    assign pairC    = termArr[4] + termArr[5];
    assign sumRes   = (pairA + pairB) + (pairC + feedBack);

endmodule

`default_nettype wire

//--- poolLanes.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnPipe_macros.svh"

module poolLanes
    import cnnDataPkg::*;
(
    input  wire        Clk,
    input  wire        rstN,
    input  dataLanes_t data,
    output wide_t      maxRes
);

    dataLanes_t                    dataReg;
    sample_t [`CNN_DATA_LANES-1:0] laneArr;
    sample_t                       best;

    // Stage two copy of the samples
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN)
            dataReg <= '0;
        else
            dataReg <= data;
    end

    assign laneArr = dataReg;

    // Signed five-way maximum
    always_comb begin
        best = laneArr[0];
        for (int i = 1; i < `CNN_DATA_LANES; i++) begin
            if (laneArr[i] > best)
                best = laneArr[i];
        end
    end

    // Widened to ALU width
    assign maxRes = wide_t'(best);

endmodule

`default_nettype wire

//--- writeBack.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnPipe_macros.svh"

module writeBack
    import cnnDataPkg::*;
    import cnnCtrlPkg::*;
(
    input  wire       Clk,
    input  wire       rstN,
    input  ctrlWord_t ctrl,
    input  wide_t     sumRes,
    input  wide_t     maxRes,
    output wide_t     accRes,
    output sample_t   writeData,
    output logic      computeDone
);

    // Most negative sample, latch floor
    localparam sample_t minSample = {1'b1, {(`CNN_SAMPLE_W-1){1'b0}}};

    // Stage two control, aligned with sumRes and maxRes
    logic selMaxReg;
    logic runMaxReg;
    logic clrMaxReg;
    logic doneReg;

    wide_t   aluRes;
    sample_t aluLow;
    sample_t maxLatch;
    sample_t larger;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            selMaxReg <= 1'b0;
            runMaxReg <= 1'b0;
            clrMaxReg <= 1'b0;
            doneReg   <= 1'b0;
        end else begin
            selMaxReg <= ctrl.selectMax;
            runMaxReg <= ctrl.runningMax;
            clrMaxReg <= ctrl.clearMax;
            doneReg   <= ctrl.done;
        end
    end

    ////////////////////////////////
    // ALU select and latch compare
    ////////////////////////////////

    assign aluRes = selMaxReg ? maxRes : sumRes;
    assign aluLow = aluRes[`CNN_SAMPLE_W-1:0];
    // Signed compare against the ALU result itself
    assign larger = (aluLow > maxLatch) ? aluLow : maxLatch;

    // Edge k+2, outputs, feedback and latch
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            accRes      <= '0;
            writeData   <= '0;
            computeDone <= 1'b0;
            maxLatch    <= minSample;
        end else begin
            accRes      <= aluRes;
            writeData   <= runMaxReg ? larger : aluLow;
            computeDone <= doneReg;
            // Clear wins over update
            if (clrMaxReg)
                maxLatch <= minSample;
            else if (runMaxReg)
                maxLatch <= larger;
        end
    end

endmodule

`default_nettype wire

//--- cnnPipeTop.sv
`timescale 1ns/10ps
`default_nettype none

module cnnPipeTop
    import cnnDataPkg::*;
    import cnnCtrlPkg::*;
(
    input  wire          Clk,
    input  wire          rstN,
    input  wire          enable,
    input  ctrlWord_t    ctrl,
    input  dataLanes_t   data,
    input  weightLanes_t weight,
    output sample_t      writeData,
    output logic         computeDone
);

    // Stage one outputs
    ctrlWord_t    ctrlS1;
    dataLanes_t   dataS1;
    weightLanes_t weightS1;

    // Path results and feedback
    wide_t sumRes;
    wide_t maxRes;
    wide_t accRes;

    ////////////////////////////////
    // Stage one
    ////////////////////////////////

    operandStage u_operandStage (
        .Clk       (Clk),
        .rstN      (rstN),
        .enable    (enable),
        .ctrlIn    (ctrl),
        .dataIn    (data),
        .weightIn  (weight),
        .ctrlOut   (ctrlS1),
        .dataOut   (dataS1),
        .weightOut (weightS1)
    );

    ////////////////////////////////
    // Stage two, both paths
    ////////////////////////////////

    macLanes u_macLanes (
        .Clk    (Clk),
        .rstN   (rstN),
        .ctrl   (ctrlS1),
        .data   (dataS1),
        .weight (weightS1),
        .accRes (accRes),
        .sumRes (sumRes)
    );

    poolLanes u_poolLanes (
        .Clk    (Clk),
        .rstN   (rstN),
        .data   (dataS1),
        .maxRes (maxRes)
    );

    // Stage three, select and write
    writeBack u_writeBack (
        .Clk         (Clk),
        .rstN        (rstN),
        .ctrl        (ctrlS1),
        .sumRes      (sumRes),
        .maxRes      (maxRes),
        .accRes      (accRes),
        .writeData   (writeData),
        .computeDone (computeDone)
    );

endmodule

`default_nettype wire

//--- cnnPipe_asserts.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnPipe_macros.svh"

module cnnPipeAsserts
    import cnnDataPkg::*;
    import cnnCtrlPkg::*;
(
    input wire       Clk,
    input wire       rstN,
    input wire       enable,
    input ctrlWord_t ctrl,
    input wide_t     accRes,
    input sample_t   writeData,
    input wire       computeDone
);

    // Failure tally
    int unsigned failCount = 0;

    // runningMax as the DUT sees it, bubbles carry none
    logic liveRunMax;
    assign liveRunMax = enable && ctrl.runningMax;

    //////////////////////////////
    // Output checks
    //////////////////////////////

    // No done pulse inside reset
    assert property (@(posedge Clk) !rstN |-> !computeDone)
        else begin
            $error("computeDone high while rstN low");
            failCount++;
        end

    // Sampled outputs belong to the inputs sampled three edges back
    assert property (@(posedge Clk) disable iff (!rstN) computeDone |-> $past(enable, 3))
        else begin
            $error("computeDone high for an item that entered with enable low");
            failCount++;
        end

    // Without the latch writeData is the ALU low half, same as accRes
    assert property (@(posedge Clk) disable iff (!rstN)
        !$past(liveRunMax, 3) |-> writeData == accRes[`CNN_SAMPLE_W-1:0])
        else begin
            $error("writeData differs from ALU low bits with runningMax off");
            failCount++;
        end

endmodule

`default_nettype wire

//--- cnnPipeTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cnnPipe_macros.svh"

module cnnPipeTb
    import cnnDataPkg::*;
    import cnnCtrlPkg::*;
();

    // One table row with stimulus and expected outputs
    typedef struct packed {
        logic [2:0]   testId;
        logic         enable;
        ctrlWord_t    ctrl;
        dataLanes_t   data;
        weightLanes_t weight;
        sample_t      expData;
        logic         expDone;
    } tbRow_t;

    typedef logic [`CNN_TERM_LANES-1:0] laneMask_t;

    localparam int numTests = 6;
    // Latch value after clear
    localparam sample_t floorSample = {1'b1, {(`CNN_SAMPLE_W-1){1'b0}}};

    logic         Clk;
    logic         rstN;
    logic         enable;
    ctrlWord_t    ctrl;
    dataLanes_t   data;
    weightLanes_t weight;
    sample_t      writeData;
    logic         computeDone;

    tbRow_t      rows[$];
    string       testNames[numTests];
    int          testErrs[numTests];
    int          testRows[numTests];
    int          errCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 100000;
    logic [2:0]  curTest;
    // Reference model state
    wide_t       refAcc = '0;
    sample_t     refLatch = floorSample;

    cnnPipeTop u_cnnPipeTop (
        .Clk         (Clk),
        .rstN        (rstN),
        .enable      (enable),
        .ctrl        (ctrl),
        .data        (data),
        .weight      (weight),
        .writeData   (writeData),
        .computeDone (computeDone)
    );

    bind cnnPipeTop cnnPipeAsserts u_asserts (.*);

    // 4 ns period
    initial Clk = 1'b0;
    always #2 Clk = ~Clk;

    //////////////////////////////
    // Reference rules
    //////////////////////////////

    // Expected outputs of one item
    // Also steps the model accumulator and latch
    function automatic tbRow_t predict(tbRow_t r);
        ctrlWord_t                     c;
        sample_t [`CNN_DATA_LANES-1:0] d;
        sample_t [`CNN_TERM_LANES-1:0] w;
        wide_t                         lane;
        wide_t                         sum;
        wide_t                         alu;
        sample_t                       peak;
        sample_t                       low;
        sample_t                       larger;
        // Enable low means an idle bubble
        if (r.enable) begin
            c = r.ctrl;
            d = r.data;
            w = r.weight;
        end else begin
            c = ctrlIdle;
            d = '0;
            w = '0;
        end
        sum  = '0;
        peak = d[0];
        for (int i = 0; i < `CNN_DATA_LANES; i++) begin
            lane = d[i];
            if (c.bypass)
                sum = sum + lane;
            else if (c.laneEnable[i])
                sum = sum + lane * wide_t'(w[i]);
            if (d[i] > peak)
                peak = d[i];
        end
        // Bias only outside bypass
        if (!c.bypass && c.laneEnable[`CNN_TERM_LANES-1]) begin
            lane = w[`CNN_TERM_LANES-1];
            sum  = sum + lane;
        end
        if (c.accumulate)
            sum = sum + refAcc;
        alu    = c.selectMax ? wide_t'(peak) : sum;
        low    = alu[`CNN_SAMPLE_W-1:0];
        larger = (low > refLatch) ? low : refLatch;
        r.expData = c.runningMax ? larger : low;
        r.expDone = c.done;
        refAcc = alu;
        if (c.clearMax)
            refLatch = floorSample;
        else if (c.runningMax)
            refLatch = larger;
        return r;
    endfunction

    //////////////////////////////
    // Row builders
    //////////////////////////////

    // Flags are {bypass, accumulate, selectMax, runningMax, clearMax, done}
    function automatic ctrlWord_t makeCtrl(laneMask_t lanes, logic [5:0] flags);
        ctrlWord_t c;
        c.laneEnable = lanes;
        c.bypass     = flags[5];
        c.accumulate = flags[4];
        c.selectMax  = flags[3];
        c.runningMax = flags[2];
        c.clearMax   = flags[1];
        c.done       = flags[0];
        return c;
    endfunction

    function automatic dataLanes_t makeData(int a0, int a1, int a2, int a3, int a4);
        dataLanes_t d;
        d.lane0 = sample_t'(a0);
        d.lane1 = sample_t'(a1);
        d.lane2 = sample_t'(a2);
        d.lane3 = sample_t'(a3);
        d.lane4 = sample_t'(a4);
        return d;
    endfunction

    function automatic weightLanes_t makeWeight(int w0, int w1, int w2, int w3, int w4,
                                                int b);
        weightLanes_t w;
        w.lane0 = sample_t'(w0);
        w.lane1 = sample_t'(w1);
        w.lane2 = sample_t'(w2);
        w.lane3 = sample_t'(w3);
        w.lane4 = sample_t'(w4);
        w.bias  = sample_t'(b);
        return w;
    endfunction

    function automatic dataLanes_t randomData();
        sample_t [`CNN_DATA_LANES-1:0] d;
        for (int i = 0; i < `CNN_DATA_LANES; i++)
            d[i] = sample_t'($urandom);
        return d;
    endfunction

    function automatic weightLanes_t randomWeight();
        sample_t [`CNN_TERM_LANES-1:0] w;
        for (int i = 0; i < `CNN_TERM_LANES; i++)
            w[i] = sample_t'($urandom);
        return w;
    endfunction

    function automatic logic randBit();
        return 1'($urandom);
    endfunction

    // Hand-written expectation
    // The model still steps so its state stays in line
    task automatic addChecked(input logic en, input ctrlWord_t c, input dataLanes_t d,
                              input weightLanes_t w, input int expD, input logic expDn);
        tbRow_t r;
        r         = '0;
        r.testId  = curTest;
        r.enable  = en;
        r.ctrl    = c;
        r.data    = d;
        r.weight  = w;
        r         = predict(r);
        r.expData = sample_t'(expD);
        r.expDone = expDn;
        rows.push_back(r);
    endtask

    task automatic addPredicted(input logic en, input ctrlWord_t c, input dataLanes_t d,
                                input weightLanes_t w);
        tbRow_t r;
        r        = '0;
        r.testId = curTest;
        r.enable = en;
        r.ctrl   = c;
        r.data   = d;
        r.weight = w;
        rows.push_back(predict(r));
    endtask

    task automatic buildTable();
        testNames[0] = "reset and idle";
        testNames[1] = "multiply-accumulate";
        testNames[2] = "bypass";
        testNames[3] = "max select";
        testNames[4] = "running max";
        testNames[5] = "done";
        // Bubbles and a latch restart after a gap
        curTest = 3'd0;
        addChecked(1'b0, ctrlIdle, '0, '0, 0, 1'b0);
        addChecked(1'b0, ctrlIdle, '0, '0, 0, 1'b0);
        addChecked(1'b1, makeCtrl('0, 6'b001101), makeData(-5, -9, -100, -7, -30), '0,
                   -5, 1'b1);
        addChecked(1'b0, ctrlIdle, '0, '0, 0, 1'b0);
        addChecked(1'b1, makeCtrl('0, 6'b001100), makeData(-20, -40, -60, -80, -100), '0,
                   -20, 1'b0);
        // Full mask followed by an accumulate chain
        curTest = 3'd1;
        addChecked(1'b1, makeCtrl(6'b111111, 6'b000001), makeData(1, 2, 3, 4, 5),
                   makeWeight(10, 20, 30, 40, 50, 7), 557, 1'b1);
        addChecked(1'b1, makeCtrl(6'b010101, 6'b010000), makeData(-3, 100, 7, 100, -2),
                   makeWeight(1000, 9, -4, 9, 300, 99), -3071, 1'b0);
        addChecked(1'b1, makeCtrl(6'b100000, 6'b010000), makeData(9, 9, 9, 9, 9),
                   makeWeight(1, 1, 1, 1, 1, -1000), -4071, 1'b0);
        repeat (10)
            addPredicted(1'b1, makeCtrl(laneMask_t'($urandom), {1'b0, randBit(), 3'b000,
                         randBit()}), randomData(), randomWeight());
        // Raw samples whatever the mask
        curTest = 3'd2;
        addChecked(1'b1, makeCtrl(6'b000000, 6'b100000), makeData(100, -200, 300, -400, 32767),
                   makeWeight(3, 3, 3, 3, 3, 5000), 32567, 1'b0);
        addChecked(1'b1, makeCtrl(6'b111111, 6'b100001), makeData(-1, -2, -3, -4, -5),
                   makeWeight(3, 3, 3, 3, 3, 5000), -15, 1'b1);
        repeat (6)
            addPredicted(1'b1, makeCtrl(laneMask_t'($urandom), {1'b1, randBit(), 3'b000,
                         randBit()}), randomData(), randomWeight());
        // Pooling path wins over the sum
        curTest = 3'd3;
        addChecked(1'b1, makeCtrl(6'b111111, 6'b001000), makeData(-32768, 5, 32767, -1, 0),
                   makeWeight(2, 2, 2, 2, 2, 2), 32767, 1'b0);
        addChecked(1'b1, makeCtrl(6'b111111, 6'b001001), makeData(-300, -2, -900, -32768, -45),
                   makeWeight(2, 2, 2, 2, 2, 2), -2, 1'b1);
        repeat (6)
            addPredicted(1'b1, makeCtrl(laneMask_t'($urandom), {1'b0, randBit(), 1'b1, 2'b00,
                         randBit()}), randomData(), randomWeight());
        // Run opened by clear where the latch only climbs
        curTest = 3'd4;
        addChecked(1'b1, makeCtrl('0, 6'b001010), makeData(1, 2, 3, 4, 5), '0, 5, 1'b0);
        addChecked(1'b1, makeCtrl('0, 6'b001100), makeData(10, -4, 2, 0, 1), '0, 10, 1'b0);
        addChecked(1'b1, makeCtrl('0, 6'b001100), makeData(3, 3, 3, 3, 3), '0, 10, 1'b0);
        addChecked(1'b1, makeCtrl('0, 6'b001100), makeData(-7, -8, -9, -10, -11), '0, 10, 1'b0);
        addChecked(1'b1, makeCtrl(6'b000001, 6'b000101), makeData(200, 0, 0, 0, 0),
                   makeWeight(3, 0, 0, 0, 0, 0), 600, 1'b1);
        repeat (6)
            addPredicted(1'b1, makeCtrl(laneMask_t'($urandom), {randBit(), 1'b0, randBit(),
                         2'b10, randBit()}), randomData(), randomWeight());
        // Done bit gated by enable before fully random words
        curTest = 3'd5;
        addChecked(1'b0, makeCtrl(6'b111111, 6'b000001), makeData(1, 2, 3, 4, 5),
                   makeWeight(1, 1, 1, 1, 1, 1), 0, 1'b0);
        repeat (12)
            addPredicted($urandom_range(0, 3) != 0, makeCtrl(laneMask_t'($urandom),
                         6'($urandom)), randomData(), randomWeight());
    endtask

    //////////////////////////////
    // Drive and check
    //////////////////////////////

    task automatic driveRow(input int idx);
        if (idx < rows.size()) begin
            enable <= rows[idx].enable;
            ctrl   <= rows[idx].ctrl;
            data   <= rows[idx].data;
            weight <= rows[idx].weight;
        end else begin
            enable <= 1'b0;
            ctrl   <= ctrlIdle;
            data   <= '0;
            weight <= '0;
        end
    endtask

    task automatic checkRow(input int idx);
        tbRow_t r;
        int     id;
        r  = rows[idx];
        id = r.testId;
        if (writeData !== r.expData) begin
            $display("** Error at %0t ns: writeData expected %0d, actual %0d (row %0d)",
                     $time, r.expData, writeData, idx);
            errCount++;
            testErrs[id]++;
        end
        if (computeDone !== r.expDone) begin
            $display("** Error at %0t ns: computeDone expected %0b, actual %0b (row %0d)",
                     $time, r.expDone, computeDone, idx);
            errCount++;
            testErrs[id]++;
        end
        testRows[id]++;
        // Last row of its test
        if (idx == rows.size() - 1 || rows[idx + 1].testId != r.testId)
            $display("Test %0d %s finished: %0d rows, %0d errors", id + 1, testNames[id],
                     testRows[id], testErrs[id]);
    endtask

    initial begin
        void'($urandom(32'h393c));
        rstN    = 1'b0;
        enable  = 1'b0;
        ctrl    = ctrlIdle;
        data    = '0;
        weight  = '0;
        for (int t = 0; t < numTests; t++) begin
            testErrs[t] = 0;
            testRows[t] = 0;
        end
        buildTable();
        cycleLimit = rows.size() + 16 + 32;
        repeat (16) @(posedge Clk);
        rstN <= 1'b1;
        // Row n is sampled one edge later and its outputs land two edges after that
        for (int n = 0; n < rows.size() + 3; n++) begin
            @(posedge Clk);
            driveRow(n);
            @(negedge Clk);
            if (n >= 3)
                checkRow(n - 3);
        end
        errCount += u_cnnPipeTop.u_asserts.failCount;
        $display("Summary: %0d tests, %0d rows, %0d errors, %0d assertion failures",
                 numTests, rows.size(), errCount, u_cnnPipeTop.u_asserts.failCount);
        if (errCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Watchdog on total cycles
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Run stopped after %0d cycles without finishing the table", cycleCount);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+.
cnnDataPkg.sv
cnnCtrlPkg.sv
operandStage.sv
macLanes.sv
poolLanes.sv
writeBack.sv
cnnPipeTop.sv
cnnPipe_asserts.sv
cnnPipeTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the CNN pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cnnPipeTb -f src.f \
    && ./obj_dir/VcnnPipeTb +verilator+error+limit+1000 > sim.log 2>&1 \
    || { echo "Build or simulation returned an error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "No pass line in sim.log"; exit 1; }
echo "Simulation passed"
